// ==== bpu_config.svh ====
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

//////////////////////////////////////////////////////////////
// Branch predictor sizing
//////////////////////////////////////////////////////////////

// Data and address width of the CPU
`define BPU_XLEN 16

// Table index width, PC bits [4:1] select the entry
`define BPU_IDX_W 4

// Number of entries in the BHT and the BTB
`define BPU_DEPTH (1 << `BPU_IDX_W)

// BTB tag holds the PC bits above the index
`define BPU_TAG_W (`BPU_XLEN - `BPU_IDX_W - 1)

// Counter value after reset: weakly not taken
`define BPU_CTR_INIT 2'b01

`endif

// ==== bpu_pkg.sv ====
`include "bpu_config.svh"

package bpu_pkg;

  //////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////

  // Branch condition codes, encoding order matches the ISA
  typedef enum logic [2:0] {
    NEQ    = 3'b000, // Z = 0
    EQ     = 3'b001, // Z = 1
    GT     = 3'b010, // Z = N = 0
    LT     = 3'b011, // N = 1
    GTE    = 3'b100, // Z = 1 or Z = N = 0
    LTE    = 3'b101, // Z = 1 or N = 1
    OVFL   = 3'b110, // V = 1
    UNCOND = 3'b111  // Always
  } cond_code_e;

  // 2-bit saturating counter states, MSB set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } ctr_state_e;

  //////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////

  typedef struct packed {
    logic z; // Zero
    logic v; // Overflow
    logic n; // Negative
  } flags_t;

  // One branch candidate from decode
  typedef struct packed {
    cond_code_e            cond;             // Condition code
    logic [8:0]            offset;           // Signed word offset
    flags_t                flags;            // Flags seen by this branch
    logic [`BPU_XLEN-1:0]  rs_data;          // Target for BR
    logic                  br;               // BR (register) vs B (offset)
    logic                  branch;           // Candidate is a branch at all
    logic [`BPU_XLEN-1:0]  pc_next;          // PC+2 of the candidate
    logic [`BPU_XLEN-1:0]  predicted_target; // What fetch assumed
  } resolve_req_t;

  // Outcome handed back to the pipeline
  typedef struct packed {
    logic [`BPU_XLEN-1:0] actual_target; // Where fetch should be
    logic                 taken;
    logic                 mispredicted;  // Redirect fetch when set
    logic [`BPU_XLEN-1:0] pc_next;
  } resolve_res_t;

  // Writes into the BHT and the BTB
  typedef struct packed {
    logic [`BPU_XLEN-1:0] pc;     // Address of the branch itself
    logic                 taken;  // Counter direction
    logic [`BPU_XLEN-1:0] target; // Computed target for the BTB
    logic                 wen_bht;
    logic                 wen_btb;
  } table_update_t;

endpackage

// ==== cla_16bit.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two-level carry-lookahead adder, four 4-bit groups
module cla_16bit (
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        sub,  // a - b when set
  output logic [15:0] sum,
  output logic        cout
);

  logic [15:0] b_eff;  // b, inverted for subtract
  logic [15:0] p;      // Bit propagate
  logic [15:0] g;      // Bit generate
  logic [15:0] c;      // Carry into each bit
  logic [3:0]  gg;     // Group generate
  logic [3:0]  gp;     // Group propagate
  logic [4:0]  gc;     // Carry into each group, gc[4] is carry out

  assign b_eff = b ^ {16{sub}};
  assign p     = a ^ b_eff;
  assign g     = a & b_eff;

  //////////////////////////////////////////////////////////////
  // First level: group terms and carries inside each group
  //////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      gg[k] = g[4*k+3] | (p[4*k+3] & g[4*k+2]) | (p[4*k+3] & p[4*k+2] & g[4*k+1]) |
              (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
      gp[k] = &p[4*k +: 4];
      c[4*k]   = gc[k];                                             // Group carry in
      c[4*k+1] = g[4*k] | (p[4*k] & gc[k]);
      c[4*k+2] = g[4*k+1] | (p[4*k+1] & g[4*k]) | (p[4*k+1] & p[4*k] & gc[k]);
      c[4*k+3] = g[4*k+2] | (p[4*k+2] & g[4*k+1]) | (p[4*k+2] & p[4*k+1] & g[4*k]) |
                 (p[4*k+2] & p[4*k+1] & p[4*k] & gc[k]);
    end
  end

  //////////////////////////////////////////////////////////////
  // Second level: lookahead across groups
  //////////////////////////////////////////////////////////////
  assign gc[0] = sub;                                           // +1 completes two's complement
  assign gc[1] = gg[0] | (gp[0] & gc[0]);
  assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & gc[0]);
  assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0]) |
                 (gp[2] & gp[1] & gp[0] & gc[0]);
  assign gc[4] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1]) |
                 (gp[3] & gp[2] & gp[1] & gg[0]) | (gp[3] & gp[2] & gp[1] & gp[0] & gc[0]);

  assign sum  = p ^ c;
  assign cout = gc[4];

endmodule

`default_nettype wire

// ==== branch_control.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bpu_config.svh"

// Resolves one decode-stage branch and forms the table writes
module branch_control (
  input  bpu_pkg::resolve_req_t  req,
  output bpu_pkg::resolve_res_t  res,
  output bpu_pkg::table_update_t upd
);

  logic [`BPU_XLEN-1:0] sext_offset;     // Offset widened to 16 bits
  logic [`BPU_XLEN-1:0] shifted_offset;  // Word offset to byte offset
  logic [`BPU_XLEN-1:0] pc_b;            // PC+2 plus offset, for B
  logic [`BPU_XLEN-1:0] pc_branch;       // Computed target, B or BR
  logic [`BPU_XLEN-1:0] branch_pc;       // Address of the branch itself
  logic                 taken_cond;      // Condition holds on the flags
  logic                 branch_taken;
  logic                 target_miss;     // BTB held a different target

  //////////////////////////////////////////////////////////////
  // Target arithmetic
  //////////////////////////////////////////////////////////////
  assign sext_offset    = {{(`BPU_XLEN-9){req.offset[8]}}, req.offset};
  assign shifted_offset = {sext_offset[`BPU_XLEN-2:0], 1'b0};

  cla_16bit target_adder (
    .a    (req.pc_next),
    .b    (shifted_offset),
    .sub  (1'b0),
    .sum  (pc_b),
    .cout ()                    // Address wraps, carry unused
  );

  // Step back from PC+2 to the branch's own PC for table indexing
  cla_16bit pc_adder (
    .a    (req.pc_next),
    .b    (`BPU_XLEN'd2),
    .sub  (1'b1),
    .sum  (branch_pc),
    .cout ()
  );

  //////////////////////////////////////////////////////////////
  // Condition evaluation
  //////////////////////////////////////////////////////////////
  always_comb begin
    case (req.cond)
      bpu_pkg::NEQ:    taken_cond = ~req.flags.z;
      bpu_pkg::EQ:     taken_cond = req.flags.z;
      bpu_pkg::GT:     taken_cond = ~req.flags.z & ~req.flags.n;
      bpu_pkg::LT:     taken_cond = req.flags.n;
      bpu_pkg::GTE:    taken_cond = req.flags.z | (~req.flags.z & ~req.flags.n);
      bpu_pkg::LTE:    taken_cond = req.flags.z | req.flags.n;
      bpu_pkg::OVFL:   taken_cond = req.flags.v;
      bpu_pkg::UNCOND: taken_cond = 1'b1;
      default:         taken_cond = 1'b0;  // Unreachable for a 3-bit code
    endcase
  end

  // Resolution
  assign pc_branch    = req.br ? req.rs_data : pc_b;       // BR uses the register
  assign branch_taken = req.branch & taken_cond;
  assign target_miss  = (req.predicted_target != pc_branch);

  assign res.actual_target = branch_taken ? pc_branch : req.pc_next;
  assign res.taken         = branch_taken;
  assign res.mispredicted  = (req.predicted_target != res.actual_target);
  assign res.pc_next       = req.pc_next;

  // Table writes
  assign upd.pc      = branch_pc;
  assign upd.taken   = branch_taken;
  assign upd.target  = pc_branch;                                // BTB keeps computed target
  assign upd.wen_bht = req.branch;                               // Train on every branch
  assign upd.wen_btb = req.branch & (taken_cond | target_miss);

endmodule

`default_nettype wire

// ==== branch_history_table.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bpu_config.svh"

// Direct-indexed table of 2-bit saturating counters
module branch_history_table (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`BPU_XLEN-1:0]   rd_pc,     // Fetch PC
  output logic                   rd_taken,  // Predict taken
  input  bpu_pkg::table_update_t upd,
  input  logic                   upd_en     // Request accepted this edge
);

  bpu_pkg::ctr_state_e  ctr [`BPU_DEPTH];
  logic [`BPU_IDX_W-1:0] rd_idx;
  logic [`BPU_IDX_W-1:0] wr_idx;
  bpu_pkg::ctr_state_e  ctr_cur;            // Counter being trained
  bpu_pkg::ctr_state_e  ctr_nxt;

  // Halfword aligned PCs, bit 0 is never part of the index
  assign rd_idx = rd_pc[`BPU_IDX_W:1];
  assign wr_idx = upd.pc[`BPU_IDX_W:1];

  //////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////
  assign rd_taken = (ctr[rd_idx] == bpu_pkg::WEAK_T) ||
                    (ctr[rd_idx] == bpu_pkg::STRONG_T);

  //////////////////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////////////////
  assign ctr_cur = ctr[wr_idx];

  // One step toward the outcome, held at the ends
  always_comb begin
    ctr_nxt = ctr_cur;
    case (ctr_cur)
      bpu_pkg::STRONG_NT: ctr_nxt = upd.taken ? bpu_pkg::WEAK_NT : bpu_pkg::STRONG_NT;
      bpu_pkg::WEAK_NT:   ctr_nxt = upd.taken ? bpu_pkg::WEAK_T : bpu_pkg::STRONG_NT;
      bpu_pkg::WEAK_T:    ctr_nxt = upd.taken ? bpu_pkg::STRONG_T : bpu_pkg::WEAK_NT;
      bpu_pkg::STRONG_T:  ctr_nxt = upd.taken ? bpu_pkg::STRONG_T : bpu_pkg::WEAK_T;
      default:            ctr_nxt = bpu_pkg::ctr_state_e'(`BPU_CTR_INIT);
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BPU_DEPTH; i++) begin
        ctr[i] <= bpu_pkg::ctr_state_e'(`BPU_CTR_INIT);  // Weakly not taken
      end
    end else if (upd_en && upd.wen_bht) begin
      ctr[wr_idx] <= ctr_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== branch_target_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bpu_config.svh"

// Direct-mapped, tagged branch target store
module branch_target_buffer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`BPU_XLEN-1:0]   rd_pc,      // Fetch PC
  output logic                   hit,        // Valid entry with matching tag
  output logic [`BPU_XLEN-1:0]   rd_target,
  input  bpu_pkg::table_update_t upd,
  input  logic                   upd_en      // Request accepted this edge
);

  logic [`BPU_TAG_W-1:0] tag_mem [`BPU_DEPTH];
  logic [`BPU_XLEN-1:0]  tgt_mem [`BPU_DEPTH];
  logic [`BPU_DEPTH-1:0] valid;

  logic [`BPU_IDX_W-1:0] rd_idx;
  logic [`BPU_TAG_W-1:0] rd_tag;
  logic [`BPU_IDX_W-1:0] wr_idx;
  logic [`BPU_TAG_W-1:0] wr_tag;
  logic                  wr_en;

  //////////////////////////////////////////////////////////////
  // Address split
  //////////////////////////////////////////////////////////////
  // PC = {tag, index, 1'b0}
  assign rd_idx = rd_pc[`BPU_IDX_W:1];
  assign rd_tag = rd_pc[`BPU_XLEN-1:`BPU_IDX_W+1];
  assign wr_idx = upd.pc[`BPU_IDX_W:1];
  assign wr_tag = upd.pc[`BPU_XLEN-1:`BPU_IDX_W+1];

  assign wr_en = upd_en & upd.wen_btb;

  //////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////
  assign hit       = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign rd_target = tgt_mem[rd_idx];  // Only meaningful on hit

  //////////////////////////////////////////////////////////////
  // Write
  //////////////////////////////////////////////////////////////
  // Valid bits are control state
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Tag and target storage, qualified by valid
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx] <= wr_tag;
      tgt_mem[wr_idx] <= upd.target;
    end
  end

endmodule

`default_nettype wire

// ==== branch_predict_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bpu_config.svh"

// Branch prediction and resolution subsystem
module branch_predict_unit (
  input  logic                  clk,
  input  logic                  reset,

  // Fetch lookup, same cycle
  input  logic [`BPU_XLEN-1:0]  fetch_pc,
  output logic [`BPU_XLEN-1:0]  predicted_pc,

  // Decode-stage branch candidate
  input  bpu_pkg::resolve_req_t resolve_req,
  input  logic                  resolve_valid,
  output logic                  resolve_ready,

  // Resolution back to the pipeline
  output bpu_pkg::resolve_res_t result,
  output logic                  result_valid,
  input  logic                  result_ready
);

  logic [`BPU_XLEN-1:0]   fetch_seq;   // Fall-through fetch address
  logic                   bht_taken;
  logic                   btb_hit;
  logic [`BPU_XLEN-1:0]   btb_target;
  bpu_pkg::resolve_res_t  res;         // Combinational resolution
  bpu_pkg::table_update_t upd;
  logic                   accept;      // Request handshake completes

  //////////////////////////////////////////////////////////////
  // Fetch prediction
  //////////////////////////////////////////////////////////////
  assign fetch_seq = fetch_pc + `BPU_XLEN'd2;

  branch_history_table bht (
    .clk      (clk),
    .reset    (reset),
    .rd_pc    (fetch_pc),
    .rd_taken (bht_taken),
    .upd      (upd),
    .upd_en   (accept)
  );

  branch_target_buffer btb (
    .clk       (clk),
    .reset     (reset),
    .rd_pc     (fetch_pc),
    .hit       (btb_hit),
    .rd_target (btb_target),
    .upd       (upd),
    .upd_en    (accept)
  );

  // Redirect only when the counter says taken and the BTB knows where
  assign predicted_pc = (bht_taken && btb_hit) ? btb_target : fetch_seq;

  //////////////////////////////////////////////////////////////
  // Resolution
  //////////////////////////////////////////////////////////////
  branch_control ctrl (
    .req (resolve_req),
    .res (res),
    .upd (upd)
  );

  // One-entry result slot, free when empty or draining this cycle
  assign resolve_ready = !result_valid || result_ready;
  assign accept        = resolve_valid && resolve_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (accept) begin
      result_valid <= 1'b1;             // Back-to-back when draining
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  // Payload only loads on accept, so it holds while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      result <= res;
    end
  end

endmodule

`default_nettype wire

// ==== tb_branch_predict_unit.sv ====
`timescale 1ns/1ps
`include "bpu_config.svh"

// Testbench for the branch prediction and resolution subsystem
module tb_branch_predict_unit;

  logic                  clk;
  logic                  reset;
  logic [`BPU_XLEN-1:0]  fetch_pc;
  logic [`BPU_XLEN-1:0]  predicted_pc;
  bpu_pkg::resolve_req_t resolve_req;
  logic                  resolve_valid;
  logic                  resolve_ready;
  bpu_pkg::resolve_res_t result;
  logic                  result_valid;
  logic                  result_ready;

  // One entry per stimulus line
  string                 names [$];
  logic [`BPU_XLEN-1:0]  fetch_q [$];
  bpu_pkg::resolve_req_t req_q [$];
  int                    stall_q [$];    // File stall plus random extra
  logic [`BPU_XLEN-1:0]  pred_q [$];     // Expected predicted_pc
  bpu_pkg::resolve_res_t exp_q [$];      // Expected result from the file

  int errors      = 0;
  int checks      = 0;
  int cycles      = 0;
  int cycle_limit = 1000;                // Replaced once the vectors are known
  bit loaded;

  branch_predict_unit dut0 (
    .clk           (clk),
    .reset         (reset),
    .fetch_pc      (fetch_pc),
    .predicted_pc  (predicted_pc),
    .resolve_req   (resolve_req),
    .resolve_valid (resolve_valid),
    .resolve_ready (resolve_ready),
    .result        (result),
    .result_valid  (result_valid),
    .result_ready  (result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;              // 100 ns period
  end

  // Watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  // Outcome of one candidate from the condition and target rules
  function automatic bpu_pkg::resolve_res_t expected_outcome(input bpu_pkg::resolve_req_t r);
    bpu_pkg::resolve_res_t o;
    logic                  cond_ok;
    logic [`BPU_XLEN-1:0]  target;
    case (r.cond)
      bpu_pkg::NEQ:  cond_ok = !r.flags.z;
      bpu_pkg::EQ:   cond_ok = r.flags.z;
      bpu_pkg::GT:   cond_ok = !(r.flags.z || r.flags.n);
      bpu_pkg::LT:   cond_ok = r.flags.n;
      bpu_pkg::GTE:  cond_ok = r.flags.z || !r.flags.n;  // Equal or positive
      bpu_pkg::LTE:  cond_ok = r.flags.z || r.flags.n;
      bpu_pkg::OVFL: cond_ok = r.flags.v;
      default:       cond_ok = 1'b1;                     // UNCOND
    endcase
    if (r.br) begin
      target = r.rs_data;
    end else begin
      target = r.pc_next + {{(`BPU_XLEN-10){r.offset[8]}}, r.offset, 1'b0};  // Word to byte
    end
    o.taken         = r.branch && cond_ok;
    o.actual_target = o.taken ? target : r.pc_next;
    o.mispredicted  = (r.predicted_target != o.actual_target);
    o.pc_next       = r.pc_next;
    return o;
  endfunction

  task automatic compare_field(input string test, input string field,
                               input logic [`BPU_XLEN-1:0] exp_val,
                               input logic [`BPU_XLEN-1:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test, field, exp_val, act_val);
    end
  endtask

  // Reads every vector before the run so the timeout can be sized
  task automatic load_vectors(output bit ok);
    int                    fd;
    int                    n;
    int                    stall;
    int                    max_stall;
    string                 line;
    string                 name;
    logic [`BPU_XLEN-1:0]  fpc, rs, pcn, ptgt, epred, eact;
    logic [2:0]            cond;
    logic [8:0]            off;
    logic [2:0]            zvn;
    logic                  br, brn, etk, emp;
    bpu_pkg::resolve_req_t r;
    bpu_pkg::resolve_res_t e;
    max_stall = 0;
    fd = $fopen("branch_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and column notes
          n = $sscanf(line, "%s %h %h %h %b %h %b %b %h %h %d %h %h %b %b",
                      name, fpc, cond, off, zvn, rs, br, brn, pcn, ptgt,
                      stall, epred, eact, etk, emp);
          if (n == 15) begin
            r                  = '0;
            r.cond             = bpu_pkg::cond_code_e'(cond);
            r.offset           = off;
            r.flags            = bpu_pkg::flags_t'(zvn);
            r.rs_data          = rs;
            r.br               = br;
            r.branch           = brn;
            r.pc_next          = pcn;
            r.predicted_target = ptgt;
            e.actual_target    = eact;
            e.taken            = etk;
            e.mispredicted     = emp;
            e.pc_next          = pcn;
            stall = stall + int'($urandom % 3);                // Up to two extra stalls
            if (stall > max_stall) max_stall = stall;
            names.push_back(name);
            fetch_q.push_back(fpc);
            req_q.push_back(r);
            stall_q.push_back(stall);
            pred_q.push_back(epred);
            exp_q.push_back(e);
          end else begin
            errors++;
            $display("Stimulus line could not be parsed: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = names.size() * (2 + max_stall) + 20;
    ok = (fd != 0) && (names.size() > 0);
  endtask

  // Result of vector i, present from the edge after its accept
  task automatic check_result(input int i);
    bpu_pkg::resolve_res_t model;
    model = expected_outcome(req_q[i]);
    if (!result_valid) begin
      errors++;
      $display("%s: result_valid is not high one cycle after the accept", names[i]);
    end
    compare_field(names[i], "actual_target", exp_q[i].actual_target, result.actual_target);
    compare_field(names[i], "taken", exp_q[i].taken, result.taken);
    compare_field(names[i], "mispredicted", exp_q[i].mispredicted, result.mispredicted);
    compare_field(names[i], "pc_next", exp_q[i].pc_next, result.pc_next);
    compare_field(names[i], "model actual_target", model.actual_target, result.actual_target);
    compare_field(names[i], "model taken", model.taken, result.taken);
    compare_field(names[i], "model mispredicted", model.mispredicted, result.mispredicted);
  endtask

  ////////////////////////////////////////////////////////////
  // One vector, entered on a falling edge
  ////////////////////////////////////////////////////////////
  // The previous result drains at the same edge that accepts this one
  task automatic run_vector(input int i);
    bpu_pkg::resolve_res_t held;
    fetch_pc      = fetch_q[i];
    resolve_req   = req_q[i];
    resolve_valid = 1'b1;
    result_ready  = 1'b1;                                    // Lets a pending result go
    #1;
    if (i > 0) begin
      check_result(i - 1);                                   // Still held until the edge
    end
    compare_field(names[i], "predicted_pc", pred_q[i], predicted_pc);
    if (!resolve_ready) begin
      errors++;
      $display("%s: resolve_ready low while the result slot is free or draining", names[i]);
    end
    while (!resolve_ready) begin                             // Watchdog bounds this
      @(negedge clk);
      #1;
    end
    @(posedge clk);                                          // Accept edge
    @(negedge clk);
    if (stall_q[i] > 0) begin
      resolve_valid = 1'b0;
      resolve_req   = '0;
      result_ready  = 1'b0;
      #1;
      check_result(i);
      if (resolve_ready) begin
        errors++;
        $display("%s: resolve_ready high while a result is waiting", names[i]);
      end
      held = result;
      // Output stalled, result must hold
      for (int s = 1; s < stall_q[i]; s++) begin
        @(negedge clk);
        #1;
        if (!result_valid || result !== held) begin
          errors++;
          $display("%s: result changed or dropped while stalled", names[i]);
        end
        if (resolve_ready) begin
          errors++;
          $display("%s: resolve_ready high while the result is stalled", names[i]);
        end
      end
      @(negedge clk);                                        // Released by the next step
    end
  endtask

  initial begin
    reset         = 1'b1;
    fetch_pc      = '0;
    resolve_req   = '0;
    resolve_valid = 1'b0;
    result_ready  = 1'b1;
    void'($urandom(48));
    load_vectors(loaded);
    if (!loaded) begin
      $display("Stimulus file branch_stimulus.txt could not be read");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #1;
      if (result_valid !== 1'b0) begin
        errors++;
        $display("result_valid is not low after reset");
      end
      if (resolve_ready !== 1'b1) begin
        errors++;
        $display("resolve_ready is not high after reset");
      end
      // Cold tables give fall-through for every stimulus PC
      for (int k = 0; k < fetch_q.size(); k++) begin
        @(negedge clk);
        fetch_pc = fetch_q[k];
        #1;
        compare_field(names[k], "cold predicted_pc", fetch_q[k] + `BPU_XLEN'd2, predicted_pc);
      end
      @(negedge clk);
      for (int i = 0; i < names.size(); i++) begin
        run_vector(i);
      end
      resolve_valid = 1'b0;                                  // Last result drains next edge
      resolve_req   = '0;
      result_ready  = 1'b1;
      #1;
      check_result(names.size() - 1);
      @(negedge clk);
      #1;
      if (result_valid) begin                                // Last result drained
        errors++;
        $display("result_valid stayed high after the last result was taken");
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

// ==== branch_stimulus.txt ====
# name fetch_pc cond offset zvn rs_data br branch pc_next predicted_target stall
#   then expected predicted_pc, actual_target, taken, mispredicted (hex and binary)
neq_taken        0120 0 008 000 0000 0 1 0204 0204 0 0122 0214 1 1
neq_not_taken    0000 0 008 100 0000 0 1 0206 0206 1 0002 0206 0 0
eq_taken         8000 1 008 100 0000 0 1 0208 0208 0 8002 0218 1 1
eq_not_taken     8010 1 008 000 0000 0 1 020A 020A 2 8012 020A 0 0
gt_taken         8020 2 008 000 0000 0 1 020C 020C 0 8022 021C 1 1
gt_not_taken_n   8030 2 008 001 0000 0 1 020E 020E 0 8032 020E 0 0
gt_not_taken_z   8040 2 008 100 0000 0 1 0210 0210 3 8042 0210 0 0
lt_taken         8050 3 008 001 0000 0 1 0212 0212 0 8052 0222 1 1
lt_not_taken     8060 3 008 000 0000 0 1 0214 0214 1 8062 0214 0 0
gte_zero         8070 4 008 100 0000 0 1 0216 0216 0 8072 0226 1 1
gte_positive     8080 4 008 000 0000 0 1 0218 0218 0 8082 0228 1 1
gte_negative     8090 4 008 001 0000 0 1 021A 021A 2 8092 021A 0 0
lte_zero         80A0 5 008 100 0000 0 1 021C 021C 0 80A2 022C 1 1
lte_negative     80B0 5 008 001 0000 0 1 021E 021E 0 80B2 022E 1 1
lte_positive     80C0 5 008 000 0000 0 1 0220 0220 1 80C2 0220 0 0
ovfl_taken       80D0 6 008 010 0000 0 1 0404 0404 0 80D2 0414 1 1
ovfl_not_taken   80E0 6 008 101 0000 0 1 0406 0406 0 80E2 0406 0 0
uncond_clear     80F0 7 008 000 0000 0 1 0408 0408 3 80F2 0418 1 1
uncond_all       8100 7 008 111 0000 0 1 040A 040A 0 8102 041A 1 1
b_positive       8110 7 040 000 0000 0 1 0304 0384 0 8112 0384 1 0
b_negative       8120 7 1F0 000 0000 0 1 0308 0308 1 8122 02E8 1 1
b_negative_max   8130 7 100 000 0000 0 1 0608 0408 0 8132 0408 1 0
b_wrap           8140 7 010 000 0000 0 1 FFF0 FFF0 0 8142 0010 1 1
br_register      8150 7 005 000 1234 1 1 030C 1234 2 8152 1234 1 0
br_not_taken     8160 1 005 000 ABCD 1 1 0310 0310 0 8162 0310 0 0
no_branch        8170 7 020 000 0000 0 0 0314 0314 0 8172 0314 0 0
no_branch_stale  8180 7 020 000 0000 0 0 0318 0400 1 8182 0318 0 1
b_wrong_target   8190 7 004 000 0000 0 1 031C 0330 0 8192 0324 1 1
learn_cold       0120 7 010 000 0000 0 1 0122 0122 0 0122 0142 1 1
learn_hit        0120 7 010 000 0000 0 1 0122 0142 1 0142 0142 1 0
learn_tag_miss   0020 7 010 000 0000 0 0 0324 0324 0 0022 0324 0 0
learn_nt_first   0120 1 010 000 0000 0 1 0122 0142 0 0142 0122 0 1
learn_nt_second  0120 1 010 000 0000 0 1 0122 0142 2 0142 0122 0 1
learn_sequential 0120 1 010 000 0000 0 1 0122 0122 0 0122 0122 0 0
learn_retrain    0120 7 010 000 0000 0 1 0122 0122 0 0122 0142 1 1
learn_weak       0120 7 010 000 0000 0 1 0122 0122 0 0122 0142 1 1
learn_taken      0120 7 010 000 0000 0 0 0330 0330 3 0142 0330 0 0

// ==== tb.f ====
+incdir+.
bpu_pkg.sv
cla_16bit.sv
branch_control.sv
branch_history_table.sv
branch_target_buffer.sv
branch_predict_unit.sv
tb_branch_predict_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
# Result comes from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f tb.f \
  --top-module tb_branch_predict_unit -o sim_bpu > sim.log 2>&1 &&
  ./obj_dir/sim_bpu >> sim.log 2>&1 ||
  echo "Build or simulation did not complete" >> sim.log

cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
